// File: mips_backend.f
mips_pkg.sv
mips_pipe_if.sv
mips_regfile.sv
mips_execute.sv
mips_mem_stage.sv
mips_data_ram.sv
mips_backend.sv
mips_backend_sva.sv
tb_mips_backend.sv

// File: Makefile
# Verilator simulation of the pipeline back end
BIN := obj_dir/Vtb_mips_backend

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a listed source changes
$(BIN): mips_backend.f $(shell cat mips_backend.f)
	verilator --binary --timing --assert --top-module tb_mips_backend -f mips_backend.f

# Passes only when the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// File: tb_mips_backend.sv
`timescale 1ns/1ps

module tb_mips_backend import mips_pkg::*; ();

    // Expected result of one issued slot
    typedef struct packed {
        logic              vld;
        logic              br;     // Branch checked one edge after issue
        logic              taken;
        logic [XLEN-1:0]   target;
        logic              wr;     // Real register write
        logic [NB_REG-1:0] dest;
        logic [XLEN-1:0]   data;
    } exp_t;

    logic              i_clk;
    logic              i_rst;
    logic              i_valid;
    mips_op_t          i_op;
    logic [XLEN-1:0]   i_pc;
    logic [XLEN-1:0]   i_imm;
    logic [NB_REG-1:0] i_rs;
    logic [NB_REG-1:0] i_rt;
    logic [NB_REG-1:0] i_rd;
    logic              o_pc_src;
    logic [XLEN-1:0]   o_branch_target;
    logic              o_wb_valid;
    logic [NB_REG-1:0] o_wb_dest;
    logic [XLEN-1:0]   o_wb_data;

    logic [XLEN-1:0]   reg_model [NUM_REGS];
    logic [7:0]        mem_model [RAM_WORDS*NB_BE]; // 4 KiB byte addressed
    exp_t              p1;                          // Issued one edge ago
    exp_t              p2;                          // Issued two edges ago
    logic [NB_REG-1:0] d1;                          // Dest of last issue
    logic [NB_REG-1:0] d2;
    int                errors;
    int                tests_passed;
    int                tests_failed;

    mips_backend i_mips_backend (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_valid         (i_valid),
        .i_op            (i_op),
        .i_pc            (i_pc),
        .i_imm           (i_imm),
        .i_rs            (i_rs),
        .i_rt            (i_rt),
        .i_rd            (i_rd),
        .o_pc_src        (o_pc_src),
        .o_branch_target (o_branch_target),
        .o_wb_valid      (o_wb_valid),
        .o_wb_dest       (o_wb_dest),
        .o_wb_data       (o_wb_data)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk; // 4 ns period
    end

    ////////////////////////////////////////
    // Reference model helpers
    ////////////////////////////////////////
    function automatic logic [XLEN-1:0] load_value(input mips_op_t op, input logic [11:0] ad);
        logic [7:0]  bt;
        logic [15:0] hw;
        bt = mem_model[ad];
        hw = {mem_model[ad + 12'd1], mem_model[ad]}; // Little endian
        case (op)
            OP_LB:   return {{24{bt[7]}}, bt};
            OP_LBU:  return {24'b0, bt};
            OP_LH:   return {{16{hw[15]}}, hw};
            OP_LHU:  return {16'b0, hw};
            default: return {mem_model[ad + 12'd3], mem_model[ad + 12'd2], hw};
        endcase
    endfunction

    task automatic store_value(input mips_op_t op, input logic [11:0] ad,
                               input logic [XLEN-1:0] b);
        mem_model[ad] = b[7:0];
        if (op != OP_SB)
            mem_model[ad + 12'd1] = b[15:8];
        if (op == OP_SW)
        begin
            mem_model[ad + 12'd2] = b[23:16];
            mem_model[ad + 12'd3] = b[31:24];
        end
    endtask

    // True when one of the two previous issues wrote r
    function automatic logic hazard(input logic [NB_REG-1:0] r);
        return (r != '0) && ((r == d1) || (r == d2));
    endfunction

    function automatic logic [NB_REG-1:0] pick_src();
        logic [NB_REG-1:0] r;
        r = 5'($urandom_range(31));
        while (hazard(r))
            r = 5'($urandom_range(31));
        return r;
    endfunction

    function automatic logic [NB_REG-1:0] pick_dest();
        return 5'($urandom_range(31, 1));
    endfunction

    function automatic logic [XLEN-1:0] rand_imm16();
        logic [15:0] v;
        v = 16'($urandom);
        return {{16{v[15]}}, v}; // Sign extended like decode would
    endfunction

    ////////////////////////////////////////
    // Drive and check, one slot per cycle
    ////////////////////////////////////////
    task automatic mismatch(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
        $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
        errors++;
    endtask

    task automatic check_outputs();
        logic exp_src;
        logic exp_wb;
        exp_src = p1.vld && p1.br && p1.taken;
        exp_wb  = p2.vld && p2.wr;
        if (o_pc_src !== exp_src)
            mismatch("o_pc_src", 32'(exp_src), 32'(o_pc_src));
        if (p1.vld && p1.br && (o_branch_target !== p1.target))
            mismatch("o_branch_target", p1.target, o_branch_target);
        if (o_wb_valid !== exp_wb)
            mismatch("o_wb_valid", 32'(exp_wb), 32'(o_wb_valid));
        if (exp_wb && (o_wb_dest !== p2.dest))
            mismatch("o_wb_dest", 32'(p2.dest), 32'(o_wb_dest));
        if (exp_wb && (o_wb_data !== p2.data))
            mismatch("o_wb_data", p2.data, o_wb_data);
    endtask

    // Falling edge checks settled outputs and sets up the next rise
    task automatic step(input exp_t nxt, input logic vld, input mips_op_t op,
                        input logic [NB_REG-1:0] rs, input logic [NB_REG-1:0] rt,
                        input logic [NB_REG-1:0] rd, input logic [XLEN-1:0] pc,
                        input logic [XLEN-1:0] imm);
        @(negedge i_clk);
        check_outputs();
        p2      = p1;
        p1      = nxt;
        i_valid = vld;
        i_op    = op;
        i_rs    = rs;
        i_rt    = rt;
        i_rd    = rd;
        i_pc    = pc;
        i_imm   = imm;
    endtask

    task automatic bubble();
        d2 = d1;
        d1 = '0;
        step('0, 1'b0, OP_NOP, '0, '0, '0, '0, '0);
    endtask

    task automatic issue(input mips_op_t op, input logic [NB_REG-1:0] rs,
                         input logic [NB_REG-1:0] rt, input logic [NB_REG-1:0] rd,
                         input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm);
        exp_t            e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [11:0]     ad;
        logic            writes;
        int              n;
        for (n = 0; n < 2 && (hazard(rs) || hazard(rt)); n++)
            bubble(); // Wait out the writeback without forwarding
        a      = reg_model[rs];
        b      = reg_model[rt];
        ad     = 12'(a + imm); // Wraps at 4 KiB
        e      = '0;
        e.vld  = 1'b1;
        writes = 1'b1;
        case (op)
            OP_ADD:  e.data = a + b;
            OP_SUB:  e.data = a - b;
            OP_AND:  e.data = a & b;
            OP_OR:   e.data = a | b;
            OP_SLT:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: e.data = a + imm;
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU: e.data = load_value(op, ad);
            OP_SW, OP_SH, OP_SB:
            begin
                store_value(op, ad, b);
                writes = 1'b0;
            end
            OP_BEQ, OP_BNE:
            begin
                e.br     = 1'b1;
                e.taken  = (op == OP_BEQ) ? (a == b) : (a != b);
                e.target = pc + 32'd4 + (imm << 2);
                writes   = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        e.wr   = writes && (rd != '0); // r0 stays zero
        e.dest = rd;
        if (e.wr)
            reg_model[rd] = e.data;
        d2 = d1;
        d1 = e.wr ? rd : '0;
        step(e, 1'b1, op, rs, rt, rd, pc, imm);
    endtask

    // Idle slots until nothing is in flight
    task automatic drain();
        int n;
        for (n = 0; n < 8 && (p1.vld || p2.vld); n++)
            bubble();
        if (p1.vld || p2.vld)
        begin
            $display("Timeout: pipeline still busy after 8 idle cycles");
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst   = 1'b0;
        i_valid = 1'b0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b1;
        for (int r = 0; r < NUM_REGS; r++)
            reg_model[r] = '0; // Register file clears on reset
        p1 = '0;
        p2 = '0;
        d1 = '0;
        d2 = '0;
    endtask

    task automatic finish_test(input int num, input string name, input int first);
        drain();
        if (errors == first)
        begin
            tests_passed++;
            $display("Test %0d %s: PASS", num, name);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: FAIL (%0d errors)", num, name, errors - first);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic test_alu();
        mips_op_t ops [6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT, OP_ADDI};
        int       first;
        first = errors;
        for (int r = 1; r < NUM_REGS; r++)
            issue(OP_ADDI, '0, '0, 5'(r), '0, $urandom); // Seed every register
        for (int k = 0; k < 40; k++)
            issue(ops[$urandom_range(5)], pick_src(), pick_src(), pick_dest(), '0, rand_imm16());
        finish_test(1, "ALU operations", first);
    endtask

    task automatic test_word();
        logic [XLEN-1:0] addrs [8];
        int              first;
        first = errors;
        for (int k = 0; k < 8; k++)
        begin
            addrs[k] = {20'b0, 10'($urandom_range(RAM_WORDS-1)), 2'b00};
            issue(OP_SW, '0, pick_src(), '0, '0, addrs[k]); // Base r0 so imm is the address
        end
        for (int k = 0; k < 8; k++)
            issue(OP_LW, '0, '0, pick_dest(), '0, addrs[k]);
        finish_test(2, "Word store and load", first);
    endtask

    task automatic test_subword_store();
        logic [9:0] w;
        logic [1:0] off;
        logic       hsel;
        int         first;
        first = errors;
        for (int k = 0; k < 8; k++)
        begin
            w    = 10'($urandom_range(RAM_WORDS-1));
            off  = 2'($urandom_range(3));
            hsel = 1'($urandom_range(1));
            issue(OP_SW, '0, pick_src(), '0, '0, {20'b0, w, 2'b00}); // Fill word first
            issue(OP_SB, '0, pick_src(), '0, '0, {20'b0, w, off});
            issue(OP_SH, '0, pick_src(), '0, '0, {20'b0, w, hsel, 1'b0});
            issue(OP_LW, '0, '0, pick_dest(), '0, {20'b0, w, 2'b00});
        end
        finish_test(3, "Sub-word stores", first);
    endtask

    task automatic test_subword_load();
        mips_op_t          lops [4] = '{OP_LB, OP_LBU, OP_LH, OP_LHU};
        logic [XLEN-1:0]   pats [3];
        logic [NB_REG-1:0] r;
        logic [9:0]        w;
        int                first;
        first   = errors;
        pats[0] = 32'h7f80_80ff; // Mixed sign bits per lane
        pats[1] = 32'h807f_7f00;
        pats[2] = $urandom;
        for (int p = 0; p < 3; p++)
        begin
            w = 10'($urandom_range(RAM_WORDS-1));
            r = pick_dest();
            issue(OP_ADDI, '0, '0, r, '0, pats[p]);
            issue(OP_SW, '0, r, '0, '0, {20'b0, w, 2'b00});
            for (int off = 0; off < 4; off++)
                for (int o = 0; o < 4; o++)
                    if (o < 2 || (off % 2) == 0) // Halves stay aligned
                        issue(lops[o], '0, '0, pick_dest(), '0, {20'b0, w, 2'(off)});
        end
        finish_test(4, "Sub-word loads", first);
    endtask

    task automatic test_branch();
        logic [NB_REG-1:0] s;
        logic [NB_REG-1:0] t;
        int                first;
        first = errors;
        for (int k = 0; k < 16; k++)
        begin
            s = pick_src();
            t = ((k % 2) == 0) ? s : pick_src(); // Equal operands on even passes
            issue(((k % 4) < 2) ? OP_BEQ : OP_BNE, s, t, pick_dest(),
                  $urandom & 32'hffff_fffc, rand_imm16());
        end
        finish_test(5, "Branches", first);
    endtask

    task automatic test_reset_r0();
        int first;
        first = errors;
        apply_reset();
        for (int k = 0; k < 5; k++)
            bubble(); // Idle outputs checked each cycle
        issue(OP_ADD, 5'd5, '0, pick_dest(), '0, '0);   // Cleared by reset
        issue(OP_ADDI, '0, '0, '0, '0, 32'h1234_5678);  // Attempted r0 write
        bubble();
        bubble();
        issue(OP_ADD, '0, '0, pick_dest(), '0, '0);
        issue(OP_OR, '0, '0, pick_dest(), '0, '0);
        finish_test(6, "Reset and register 0", first);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial
    begin
        i_rst        = 1'b0;
        i_valid      = 1'b0;
        i_op         = OP_NOP;
        i_pc         = '0;
        i_imm        = '0;
        i_rs         = '0;
        i_rt         = '0;
        i_rd         = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'hdb09));
        for (int i = 0; i < RAM_WORDS*NB_BE; i++)
            mem_model[i] = '0;
        apply_reset();
        test_alu();
        test_word();
        test_subword_store();
        test_subword_load();
        test_branch();
        test_reset_r0();
        $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: mips_backend_sva.sv
`timescale 1ns/1ps

module mips_backend_sva import mips_pkg::*;
(
    input logic              i_clk,
    input logic              i_rst,
    input logic              i_valid,    // Issue valid, one edge ahead of MEM
    input logic              i_ram_we,
    input logic              i_pc_src,
    input logic              i_wb_valid,
    input logic [NB_REG-1:0] i_wb_dest
);

    ////////////////////////////////////////
    // Side effects need a valid instruction
    ////////////////////////////////////////
    a_ram_we_valid: assert property (@(posedge i_clk) disable iff (!i_rst)
        !i_valid |=> !i_ram_we)
        else $error("RAM write with no valid instruction in MEM");

    a_pc_src_valid: assert property (@(posedge i_clk) disable iff (!i_rst)
        !i_valid |=> !i_pc_src)
        else $error("PC source raised with no valid instruction in MEM");

    // r0 writes never show up as writeback
    a_wb_dest_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_wb_valid |-> (i_wb_dest != '0))
        else $error("Writeback valid with destination r0");

endmodule

bind mips_backend mips_backend_sva u_sva (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_ram_we    (ram_we),
    .i_pc_src    (o_pc_src),
    .i_wb_valid  (o_wb_valid),
    .i_wb_dest   (o_wb_dest)
);

// File: mips_backend.sv
`timescale 1ns/1ps

module mips_backend import mips_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_valid,
    input  mips_op_t          i_op,
    input  logic [XLEN-1:0]   i_pc,
    input  logic [XLEN-1:0]   i_imm,
    input  logic [NB_REG-1:0] i_rs,
    input  logic [NB_REG-1:0] i_rt,
    input  logic [NB_REG-1:0] i_rd,
    output logic              o_pc_src,
    output logic [XLEN-1:0]   o_branch_target,
    output logic              o_wb_valid,
    output logic [NB_REG-1:0] o_wb_dest,
    output logic [XLEN-1:0]   o_wb_data
);

    logic [XLEN-1:0]        rs_data;
    logic [XLEN-1:0]        rt_data;
    logic [NB_RAM_ADDR-1:0] ram_addr;
    logic [XLEN-1:0]        ram_wdata;
    logic [NB_BE-1:0]       ram_be;
    logic                   ram_we;
    logic [XLEN-1:0]        ram_rdata;

    ////////////////////////////////////////
    // Stage buses
    ////////////////////////////////////////
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    assign o_wb_dest = mem_wb.dest;

    mips_regfile u_regfile (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs      (i_rs),
        .i_rt      (i_rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .o_wb_we   (o_wb_valid), // Only real register writes
        .o_wb_data (o_wb_data),
        .wb        (mem_wb)
    );

    mips_execute u_execute (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_valid   (i_valid),
        .i_op      (i_op),
        .i_pc      (i_pc),
        .i_imm     (i_imm),
        .i_rd      (i_rd),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .ex        (ex_mem)
    );

    mips_mem_stage u_mem_stage (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .ex              (ex_mem),
        .wb              (mem_wb),
        .o_ram_addr      (ram_addr),
        .o_ram_wdata     (ram_wdata),
        .o_ram_be        (ram_be),
        .o_ram_we        (ram_we),
        .i_ram_rdata     (ram_rdata),
        .o_pc_src        (o_pc_src),
        .o_branch_target (o_branch_target)
    );

    mips_data_ram u_data_ram (
        .i_clk   (i_clk),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .i_be    (ram_be),
        .i_we    (ram_we),
        .o_rdata (ram_rdata)
    );

endmodule

// File: mips_data_ram.sv
`timescale 1ns/1ps

module mips_data_ram import mips_pkg::*;
(
    input  logic                   i_clk,
    input  logic [NB_RAM_ADDR-1:0] i_addr,  // Word index
    input  logic [XLEN-1:0]        i_wdata, // Lanes already placed
    input  logic [NB_BE-1:0]       i_be,
    input  logic                   i_we,
    output logic [XLEN-1:0]        o_rdata
);

    logic [XLEN-1:0] mem [RAM_WORDS]; // Contents not reset

    ////////////////////////////////////////
    // Byte-enabled write
    ////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            for (int lane = 0; lane < NB_BE; lane++)
            begin
                if (i_be[lane])
                begin
                    mem[i_addr][8*lane +: 8] <= i_wdata[8*lane +: 8];
                end
            end
        end
    end

    // Async read, serves loads in the MEM cycle
    assign o_rdata = mem[i_addr];

endmodule

// File: mips_mem_stage.sv
`timescale 1ns/1ps

module mips_mem_stage import mips_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst,
    ex_mem_if.sink                 ex,
    mem_wb_if.source               wb,
    output logic [NB_RAM_ADDR-1:0] o_ram_addr,      // Word index
    output logic [XLEN-1:0]        o_ram_wdata,
    output logic [NB_BE-1:0]       o_ram_be,
    output logic                   o_ram_we,
    input  logic [XLEN-1:0]        i_ram_rdata,
    output logic                   o_pc_src,
    output logic [XLEN-1:0]        o_branch_target
);

    logic [NB_OFFSET-1:0] byte_off;
    logic [7:0]           load_byte;
    logic [15:0]          load_half;
    logic [XLEN-1:0]      load_data;

    ////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////

    // BEQ on zero, BNE on nonzero
    assign o_pc_src = ex.valid && ex.mem_ctrl.branch
                      && (ex.mem_ctrl.branch_ne ? !ex.alu_zero : ex.alu_zero);
    assign o_branch_target = ex.branch_target;

    ////////////////////////////////////////
    // Store lane placement
    ////////////////////////////////////////
    assign byte_off   = ex.alu_result[NB_OFFSET-1:0];
    assign o_ram_addr = ex.alu_result[NB_OFFSET +: NB_RAM_ADDR]; // Wraps at 4 KiB
    assign o_ram_we   = ex.valid && ex.mem_ctrl.mem_write;

    always_comb
    begin
        if (ex.mem_ctrl.size_byte)
        begin
            o_ram_wdata = {4{ex.store_data[7:0]}};     // Byte in every lane
            o_ram_be    = NB_BE'(1) << byte_off;
        end
        else if (ex.mem_ctrl.size_half)
        begin
            o_ram_wdata = {2{ex.store_data[15:0]}};    // Half in both halves
            o_ram_be    = byte_off[1] ? 4'b1100 : 4'b0011;
        end
        else
        begin
            o_ram_wdata = ex.store_data;
            o_ram_be    = '1;                          // Full word
        end
    end

    ////////////////////////////////////////
    // Load sizing and extension
    ////////////////////////////////////////
    assign load_byte = i_ram_rdata[8*byte_off +: 8];
    assign load_half = byte_off[1] ? i_ram_rdata[31:16] : i_ram_rdata[15:0];

    always_comb
    begin
        if (!ex.mem_ctrl.mem_read)
            load_data = '0;
        else if (ex.mem_ctrl.size_byte)
            load_data = ex.mem_ctrl.is_unsigned ? {24'b0, load_byte}
                                                : {{24{load_byte[7]}}, load_byte};
        else if (ex.mem_ctrl.size_half)
            load_data = ex.mem_ctrl.is_unsigned ? {16'b0, load_half}
                                                : {{16{load_half[15]}}, load_half}; // bit 15
        else
            load_data = i_ram_rdata; // LW
    end

    ////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            wb.valid   <= 1'b0;
            wb.wb_ctrl <= '0;
        end
        else
        begin
            wb.valid   <= ex.valid;
            wb.wb_ctrl <= ex.wb_ctrl;
        end
    end

    always_ff @(posedge i_clk)
    begin
        wb.alu_result <= ex.alu_result;
        wb.read_data  <= load_data;
        wb.dest       <= ex.dest;
    end

endmodule

// File: mips_execute.sv
`timescale 1ns/1ps

module mips_execute import mips_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_valid,
    input  mips_op_t          i_op,
    input  logic [XLEN-1:0]   i_pc,
    input  logic [XLEN-1:0]   i_imm,     // Sign extended upstream
    input  logic [NB_REG-1:0] i_rd,
    input  logic [XLEN-1:0]   i_rs_data,
    input  logic [XLEN-1:0]   i_rt_data,
    ex_mem_if.source          ex
);

    alu_fn_t         alu_fn;
    logic            use_imm;   // Operand B from the immediate
    logic            writes_rd; // ALU ops and loads
    mem_ctrl_t       mem_ctrl;
    wb_ctrl_t        wb_ctrl;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] branch_target;

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////
    always_comb
    begin
        alu_fn    = ALU_ADD;
        use_imm   = 1'b0;
        writes_rd = 1'b0;
        mem_ctrl  = '0;
        wb_ctrl   = '0;
        case (i_op)
            OP_ADD:  writes_rd = 1'b1;
            OP_SUB:
            begin
                alu_fn    = ALU_SUB;
                writes_rd = 1'b1;
            end
            OP_AND:
            begin
                alu_fn    = ALU_AND;
                writes_rd = 1'b1;
            end
            OP_OR:
            begin
                alu_fn    = ALU_OR;
                writes_rd = 1'b1;
            end
            OP_SLT:
            begin
                alu_fn    = ALU_SLT;
                writes_rd = 1'b1;
            end
            OP_ADDI:
            begin
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU:
            begin
                use_imm              = 1'b1; // Address = rs + imm
                writes_rd            = 1'b1;
                mem_ctrl.mem_read    = 1'b1;
                mem_ctrl.size_half   = (i_op == OP_LH) || (i_op == OP_LHU);
                mem_ctrl.size_byte   = (i_op == OP_LB) || (i_op == OP_LBU);
                mem_ctrl.is_unsigned = (i_op == OP_LHU) || (i_op == OP_LBU);
            end
            OP_SW, OP_SH, OP_SB:
            begin
                use_imm            = 1'b1;
                mem_ctrl.mem_write = 1'b1;
                mem_ctrl.size_half = (i_op == OP_SH);
                mem_ctrl.size_byte = (i_op == OP_SB);
            end
            OP_BEQ, OP_BNE:
            begin
                alu_fn             = ALU_SUB; // Zero flag is the compare
                mem_ctrl.branch    = 1'b1;
                mem_ctrl.branch_ne = (i_op == OP_BNE);
            end
            default: ; // NOP
        endcase
        wb_ctrl.reg_write  = writes_rd && (i_rd != '0); // No write to r0
        wb_ctrl.mem_to_reg = mem_ctrl.mem_read;
        if (!i_valid)
        begin
            mem_ctrl = '0; // Bubbles carry no side effects
            wb_ctrl  = '0;
        end
    end

    ////////////////////////////////////////
    // ALU and branch target
    ////////////////////////////////////////
    assign operand_b = use_imm ? i_imm : i_rt_data;

    always_comb
    begin
        case (alu_fn)
            ALU_SUB: alu_result = i_rs_data - operand_b;
            ALU_AND: alu_result = i_rs_data & operand_b;
            ALU_OR:  alu_result = i_rs_data | operand_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(i_rs_data) < $signed(operand_b)};
            default: alu_result = i_rs_data + operand_b;
        endcase
    end

    // PC + 4 + (imm << 2)
    assign branch_target = i_pc + XLEN'(4) + {i_imm[XLEN-3:0], 2'b00};

    ////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            ex.valid    <= 1'b0;
            ex.mem_ctrl <= '0;
            ex.wb_ctrl  <= '0;
        end
        else
        begin
            ex.valid    <= i_valid;
            ex.mem_ctrl <= mem_ctrl;
            ex.wb_ctrl  <= wb_ctrl;
        end
    end

    // Payload registers
    always_ff @(posedge i_clk)
    begin
        ex.alu_result    <= alu_result;
        ex.store_data    <= i_rt_data;
        ex.alu_zero      <= (alu_result == '0);
        ex.branch_target <= branch_target;
        ex.dest          <= writes_rd ? i_rd : '0; // No destination without a write
    end

endmodule

// File: mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile import mips_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic [NB_REG-1:0] i_rs,
    input  logic [NB_REG-1:0] i_rt,
    output logic [XLEN-1:0]   o_rs_data,
    output logic [XLEN-1:0]   o_rt_data,
    output logic              o_wb_we,   // Register write this cycle
    output logic [XLEN-1:0]   o_wb_data, // Selected writeback value
    mem_wb_if.sink            wb
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic [XLEN-1:0] wb_sel;
    logic            wb_we;

    ////////////////////////////////////////
    // Writeback select
    ////////////////////////////////////////
    assign wb_sel = wb.wb_ctrl.mem_to_reg ? wb.read_data : wb.alu_result;

    // Valid instruction with a register write
    assign wb_we = wb.valid && wb.wb_ctrl.reg_write;

    assign o_wb_we   = wb_we;
    assign o_wb_data = wb_sel;

    ////////////////////////////////////////
    // Register array
    ////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0; // Clear every register
            end
        end
        else if (wb_we)
        begin
            regs[wb.dest] <= wb_sel;
        end
    end

    // Combinational reads with r0 hardwired to zero
    assign o_rs_data = (i_rs == '0) ? '0 : regs[i_rs];
    assign o_rt_data = (i_rt == '0) ? '0 : regs[i_rt];

endmodule

// File: mips_pipe_if.sv
`timescale 1ns/1ps

// Execute to memory stage register outputs
interface ex_mem_if import mips_pkg::*; ();

    logic              valid;         // Qualifies the whole bundle
    logic [XLEN-1:0]   alu_result;    // Also the load/store address
    logic [XLEN-1:0]   store_data;    // rt data, unaligned
    logic              alu_zero;      // Branch compare result
    logic [XLEN-1:0]   branch_target;
    logic [NB_REG-1:0] dest;
    mem_ctrl_t         mem_ctrl;
    wb_ctrl_t          wb_ctrl;

    modport source (
        output valid, alu_result, store_data, alu_zero,
        output branch_target, dest, mem_ctrl, wb_ctrl
    );

    modport sink (
        input valid, alu_result, store_data, alu_zero,
        input branch_target, dest, mem_ctrl, wb_ctrl
    );

endinterface

// Memory stage to writeback register outputs
interface mem_wb_if import mips_pkg::*; ();

    logic              valid;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   read_data;  // Sized and extended load data
    logic [NB_REG-1:0] dest;
    wb_ctrl_t          wb_ctrl;

    modport source (
        output valid, alu_result, read_data, dest, wb_ctrl
    );

    modport sink (
        input valid, alu_result, read_data, dest, wb_ctrl
    );

endinterface

// File: mips_pkg.sv
package mips_pkg;

    ////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////
    localparam int XLEN        = 32;                // Data and address width
    localparam int NB_REG      = 5;                 // Register index width
    localparam int NUM_REGS    = 1 << NB_REG;       // 32 GPRs
    localparam int NB_BE       = XLEN / 8;          // Byte lanes per word
    localparam int NB_OFFSET   = $clog2(NB_BE);     // Byte offset bits of an address
    localparam int NB_OP       = 5;                 // Opcode width
    localparam int RAM_WORDS   = 1024;              // 4 KiB data RAM
    localparam int NB_RAM_ADDR = $clog2(RAM_WORDS); // Word index width

    ////////////////////////////////////////
    // Opcodes, already decoded upstream
    ////////////////////////////////////////
    typedef enum logic [NB_OP-1:0] {
        OP_NOP  = 5'd0,
        // R-type and immediate ALU ops
        OP_ADD  = 5'd1,
        OP_SUB  = 5'd2,
        OP_AND  = 5'd3,
        OP_OR   = 5'd4,
        OP_SLT  = 5'd5,
        OP_ADDI = 5'd6,
        // Loads
        OP_LW   = 5'd8,
        OP_LH   = 5'd9,
        OP_LHU  = 5'd10,
        OP_LB   = 5'd11,
        OP_LBU  = 5'd12,
        // Stores
        OP_SW   = 5'd16,
        OP_SH   = 5'd17,
        OP_SB   = 5'd18,
        // Conditional branches
        OP_BEQ  = 5'd24,
        OP_BNE  = 5'd25
    } mips_op_t;

    // ALU function picked by the execute decoder
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1, // Also the branch compare
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4  // Signed compare
    } alu_fn_t;

    ////////////////////////////////////////
    // Control words carried down the pipe
    ////////////////////////////////////////

    // Memory stage controls, mem_write sits at bit 0
    typedef struct packed {
        logic branch_ne;   // BNE, taken on nonzero
        logic size_byte;   // LB/LBU/SB
        logic size_half;   // LH/LHU/SH
        logic is_unsigned; // Zero extend loads
        logic branch;      // BEQ or BNE
        logic mem_read;
        logic mem_write;
    } mem_ctrl_t;

    // Writeback controls
    typedef struct packed {
        logic reg_write;  // Write the destination
        logic mem_to_reg; // Load data instead of ALU result
    } wb_ctrl_t;

endpackage
